// File: Bender.yml
package:
  name: csr_unit

dependencies: {}

sources:
  # packages first, then the stages and the top level
  - hdl/csr_arch_pkg.sv
  - hdl/csr_bus_pkg.sv
  - hdl/csr_decode.sv
  - hdl/csr_execute.sv
  - hdl/csr_result.sv
  - hdl/csr_unit.sv

  # testbench, top module csr_unit_tb
  - target: test
    files:
      - testbench/csr_unit_tb.sv

// File: build.f
hdl/csr_arch_pkg.sv
hdl/csr_bus_pkg.sv
hdl/csr_decode.sv
hdl/csr_execute.sv
hdl/csr_result.sv
hdl/csr_unit.sv
testbench/csr_unit_tb.sv

// File: hdl/csr_arch_pkg.sv
// machine csr architecture constants
package csr_arch_pkg;

    // data and field widths
    localparam int XLEN = 32;
    localparam int CSR_ADDR_W = 12;
    localparam int CAUSE_W = 4;

    // opcodes carried on the request, 2 and 4 are unused
    typedef enum logic [2:0] {
        OP_EXCEPTION = 3'd0,
        OP_MRET      = 3'd1,
        OP_NOP       = 3'd3,
        OP_CSRRW     = 3'd5,
        OP_CSRRS     = 3'd6,
        OP_CSRRC     = 3'd7
    } csr_op_e;

    // supported machine csr addresses
    typedef enum logic [CSR_ADDR_W-1:0] {
        ADDR_MSTATUS = 12'h300,
        ADDR_MIE     = 12'h304,
        ADDR_MEPC    = 12'h341,
        ADDR_MCAUSE  = 12'h342,
        ADDR_MIP     = 12'h344
    } csr_addr_e;

    // trap vector
    localparam logic [XLEN-1:0] IRQ_HANDLER_ADDR = 32'h0000_0010;

    // mstatus bits
    localparam int BIT_MIE = 3;
    localparam int BIT_MPIE = 7;

    // mie / mip bits
    localparam int BIT_SW = 3;
    localparam int BIT_EXT = 11;

    // interrupt flag in the top bit, code below
    localparam logic [CAUSE_W:0] CAUSE_SW_IRQ = 5'b10011;
    localparam logic [CAUSE_W:0] CAUSE_EXT_IRQ = 5'b11011;

endpackage

// File: hdl/csr_bus_pkg.sv
// csr unit stage interfaces
package csr_bus_pkg;

    // request as seen at the unit boundary
    typedef struct packed {
        logic                                available;
        logic                                is_write_stage;
        csr_arch_pkg::csr_op_e               op;
        logic [csr_arch_pkg::CSR_ADDR_W-1:0] addr_exception;
        logic [csr_arch_pkg::XLEN-1:0]       write_value;
    } csr_req_t;

    // csrrw replaces, csrrs sets, csrrc clears
    typedef enum logic [1:0] {
        WR_SET_ALL,
        WR_SET,
        WR_CLEAR
    } write_mode_e;

    typedef enum logic [2:0] {
        SEL_MSTATUS,
        SEL_MIE,
        SEL_MEPC,
        SEL_MCAUSE,
        SEL_MIP,
        SEL_NONE
    } csr_sel_e;

    // decode to execute
    typedef struct packed {
        logic                             available;
        logic                             is_write_stage;
        logic                             is_exception;
        logic                             is_mret;
        logic                             is_csr;
        logic                             is_nop;
        write_mode_e                      wr_mode;
        csr_sel_e                         sel;
        logic                             invalid;
        logic [csr_arch_pkg::CAUSE_W:0]   cause;
        logic [csr_arch_pkg::XLEN-1:0]    write_value;
    } csr_decoded_t;

    // enabled fields already include the global enable
    typedef struct packed {
        logic ext_pending;
        logic ext_enabled;
        logic sw_pending;
        logic sw_enabled;
    } csr_irq_t;

endpackage

// File: hdl/csr_decode.sv
// csr request decoder
`timescale 1ns/1ps

module csr_decode (
    input  csr_bus_pkg::csr_req_t     req,
    output csr_bus_pkg::csr_decoded_t dec
);

    always_comb begin
        dec.available = req.available;
        dec.is_write_stage = req.is_write_stage;
        dec.is_exception = 1'b0;
        dec.is_mret = 1'b0;
        dec.is_csr = 1'b0;
        dec.is_nop = 1'b0;
        dec.wr_mode = csr_bus_pkg::WR_SET_ALL;
        dec.invalid = 1'b0;
        dec.cause = req.addr_exception[csr_arch_pkg::CAUSE_W:0];
        dec.write_value = req.write_value;

        // opcode class and write mode
        case (req.op)
            csr_arch_pkg::OP_EXCEPTION: dec.is_exception = 1'b1;
            csr_arch_pkg::OP_MRET:      dec.is_mret = 1'b1;
            csr_arch_pkg::OP_NOP:       dec.is_nop = 1'b1;
            csr_arch_pkg::OP_CSRRW: begin
                dec.is_csr = 1'b1;
                dec.wr_mode = csr_bus_pkg::WR_SET_ALL;
            end
            csr_arch_pkg::OP_CSRRS: begin
                dec.is_csr = 1'b1;
                dec.wr_mode = csr_bus_pkg::WR_SET;
            end
            csr_arch_pkg::OP_CSRRC: begin
                dec.is_csr = 1'b1;
                dec.wr_mode = csr_bus_pkg::WR_CLEAR;
            end
            default: dec.invalid = 1'b1;
        endcase

        // register select
        case (req.addr_exception)
            csr_arch_pkg::ADDR_MSTATUS: dec.sel = csr_bus_pkg::SEL_MSTATUS;
            csr_arch_pkg::ADDR_MIE:     dec.sel = csr_bus_pkg::SEL_MIE;
            csr_arch_pkg::ADDR_MEPC:    dec.sel = csr_bus_pkg::SEL_MEPC;
            csr_arch_pkg::ADDR_MCAUSE:  dec.sel = csr_bus_pkg::SEL_MCAUSE;
            csr_arch_pkg::ADDR_MIP:     dec.sel = csr_bus_pkg::SEL_MIP;
            default:                    dec.sel = csr_bus_pkg::SEL_NONE;
        endcase

        if (dec.is_csr && dec.sel == csr_bus_pkg::SEL_NONE) begin
            dec.invalid = 1'b1;
        end
        // mcause is read-only to software
        if (dec.is_csr && req.is_write_stage && dec.sel == csr_bus_pkg::SEL_MCAUSE) begin
            dec.invalid = 1'b1;
        end
    end

endmodule

// File: hdl/csr_execute.sv
// csr state and execution
`timescale 1ns/1ps

module csr_execute (
    input  logic                              clk,
    input  logic                              reset_n,
    input  csr_bus_pkg::csr_decoded_t         dec,
    input  logic                              ext_int,
    output logic [csr_arch_pkg::XLEN-1:0]     rd_value,
    output logic                              rd_valid,
    output logic                              fault_req,
    output csr_bus_pkg::csr_irq_t             irq
);

    // architectural state
    logic                                 mstatus_mie;
    logic                                 mstatus_mpie;
    logic                                 mie_ext;
    logic                                 mie_sw;
    logic                                 mip_ext;
    logic                                 mip_sw;
    logic [csr_arch_pkg::XLEN-1:0]        mepc;
    logic                                 mcause_irq;
    logic [csr_arch_pkg::CAUSE_W-1:0]     mcause_code;
    // enable value carried from read stage to write stage
    logic                                 latched_mie;

    logic                                 rd_phase;
    logic                                 wr_phase;
    logic [csr_arch_pkg::XLEN-1:0]        sel_word;
    logic [csr_arch_pkg::XLEN-1:0]        wr_word;

    function automatic logic [csr_arch_pkg::XLEN-1:0] csr_write(
        input logic [csr_arch_pkg::XLEN-1:0] cur,
        input logic [csr_arch_pkg::XLEN-1:0] val,
        input csr_bus_pkg::write_mode_e      mode
    );
        case (mode)
            csr_bus_pkg::WR_SET:   return cur | val;
            csr_bus_pkg::WR_CLEAR: return cur & ~val;
            default:               return val;
        endcase
    endfunction

    assign rd_phase = dec.available && !dec.is_write_stage && !dec.invalid;
    assign wr_phase = dec.available && dec.is_write_stage && !dec.invalid;

    // selected register in its architectural layout
    always_comb begin
        sel_word = '0;
        case (dec.sel)
            csr_bus_pkg::SEL_MSTATUS: begin
                sel_word[csr_arch_pkg::BIT_MIE] = mstatus_mie;
                sel_word[csr_arch_pkg::BIT_MPIE] = mstatus_mpie;
            end
            csr_bus_pkg::SEL_MIE: begin
                sel_word[csr_arch_pkg::BIT_EXT] = mie_ext;
                sel_word[csr_arch_pkg::BIT_SW] = mie_sw;
            end
            csr_bus_pkg::SEL_MEPC: sel_word = mepc;
            csr_bus_pkg::SEL_MCAUSE: begin
                sel_word[csr_arch_pkg::XLEN-1] = mcause_irq;
                sel_word[csr_arch_pkg::CAUSE_W-1:0] = mcause_code;
            end
            csr_bus_pkg::SEL_MIP: begin
                sel_word[csr_arch_pkg::BIT_EXT] = mip_ext;
                sel_word[csr_arch_pkg::BIT_SW] = mip_sw;
            end
            default: sel_word = '0;
        endcase
    end

    assign wr_word = csr_write(sel_word, dec.write_value, dec.wr_mode);

    always_comb begin
        if (dec.is_exception) begin
            rd_value = csr_arch_pkg::IRQ_HANDLER_ADDR;
        end else if (dec.is_mret) begin
            rd_value = mepc;
        end else begin
            rd_value = sel_word;
        end
    end

    assign rd_valid = rd_phase && !dec.is_nop;
    assign fault_req = dec.available && dec.invalid;

    assign irq.ext_pending = mip_ext;
    assign irq.ext_enabled = mie_ext && mstatus_mie;
    assign irq.sw_pending = mip_sw;
    assign irq.sw_enabled = mie_sw && mstatus_mie;

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            mstatus_mie <= 1'b0;
            mstatus_mpie <= 1'b0;
            mie_ext <= 1'b0;
            mie_sw <= 1'b0;
            mip_ext <= 1'b0;
            mip_sw <= 1'b0;
            mepc <= '0;
            mcause_irq <= 1'b0;
            mcause_code <= '0;
            latched_mie <= 1'b0;
        end else begin
            if (rd_phase && dec.is_exception) begin
                latched_mie <= mstatus_mie;
            end else if (rd_phase && dec.is_mret) begin
                latched_mie <= mstatus_mpie;
            end

            if (wr_phase && dec.is_exception) begin
                mcause_irq <= dec.cause[csr_arch_pkg::CAUSE_W];
                mcause_code <= dec.cause[csr_arch_pkg::CAUSE_W-1:0];
                mepc <= {dec.write_value[csr_arch_pkg::XLEN-1:2], 2'b00};
                mstatus_mpie <= latched_mie;
                mstatus_mie <= 1'b0;
                // taking an interrupt retires its pending bit
                if (dec.cause == csr_arch_pkg::CAUSE_SW_IRQ) begin
                    mip_sw <= 1'b0;
                end
                if (dec.cause == csr_arch_pkg::CAUSE_EXT_IRQ) begin
                    mip_ext <= 1'b0;
                end
            end else if (wr_phase && dec.is_mret) begin
                mstatus_mie <= latched_mie;
            end else if (wr_phase && dec.is_csr) begin
                case (dec.sel)
                    csr_bus_pkg::SEL_MSTATUS: begin
                        mstatus_mie <= wr_word[csr_arch_pkg::BIT_MIE];
                        mstatus_mpie <= wr_word[csr_arch_pkg::BIT_MPIE];
                    end
                    csr_bus_pkg::SEL_MIE: begin
                        mie_ext <= wr_word[csr_arch_pkg::BIT_EXT];
                        mie_sw <= wr_word[csr_arch_pkg::BIT_SW];
                    end
                    csr_bus_pkg::SEL_MEPC: mepc <= {wr_word[csr_arch_pkg::XLEN-1:2], 2'b00};
                    csr_bus_pkg::SEL_MIP: begin
                        mip_ext <= wr_word[csr_arch_pkg::BIT_EXT];
                        mip_sw <= wr_word[csr_arch_pkg::BIT_SW];
                    end
                    default: ;
                endcase
            end

            // sticky, wins over a clear in the same cycle
            if (ext_int) begin
                mip_ext <= 1'b1;
            end
        end
    end

    a_trap_clears_mie: assert property (
        @(posedge clk) disable iff (!reset_n)
        (wr_phase && dec.is_exception) |=> !mstatus_mie
    );

    a_mepc_aligned: assert property (
        @(posedge clk) disable iff (!reset_n)
        mepc[1:0] == 2'b00
    );

endmodule

// File: hdl/csr_result.sv
// csr output registers
`timescale 1ns/1ps

module csr_result (
    input  logic                          clk,
    input  logic                          reset_n,
    input  logic [csr_arch_pkg::XLEN-1:0] rd_value,
    input  logic                          rd_valid,
    input  logic                          fault_req,
    input  csr_bus_pkg::csr_irq_t         irq,
    output logic [csr_arch_pkg::XLEN-1:0] read_value,
    output logic                          fault,
    output logic                          ext_int_pending,
    output logic                          sw_int_pending
);

    logic ext_ready;
    logic sw_ready;

    // enabled fields already carry the global enable
    assign ext_ready = irq.ext_pending && irq.ext_enabled;
    assign sw_ready = irq.sw_pending && irq.sw_enabled;

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            fault <= 1'b0;
            ext_int_pending <= 1'b0;
            sw_int_pending <= 1'b0;
        end else begin
            fault <= fault_req;
            ext_int_pending <= ext_ready;
            sw_int_pending <= sw_ready;
        end
    end

    // holds until the next read phase
    always_ff @(posedge clk) begin
        if (rd_valid) begin
            read_value <= rd_value;
        end
    end

    a_fault_pulse: assert property (
        @(posedge clk) disable iff (!reset_n)
        (fault && $past(fault)) |-> ($past(fault_req) && $past(fault_req, 2))
    );

endmodule

// File: hdl/csr_unit.sv
// machine csr unit
`timescale 1ns/1ps

module csr_unit (
    input  logic                          clk,
    input  logic                          reset_n,
    input  csr_bus_pkg::csr_req_t         req,
    input  logic                          ext_int,
    output logic [csr_arch_pkg::XLEN-1:0] read_value,
    output logic                          fault,
    output logic                          ext_int_pending,
    output logic                          sw_int_pending
);

    csr_bus_pkg::csr_decoded_t     dec;
    logic [csr_arch_pkg::XLEN-1:0] rd_value;
    logic                          rd_valid;
    logic                          fault_req;
    csr_bus_pkg::csr_irq_t         irq;

    csr_decode u_decode (
        .req (req),
        .dec (dec)
    );

    csr_execute u_execute (
        .clk       (clk),
        .reset_n   (reset_n),
        .dec       (dec),
        .ext_int   (ext_int),
        .rd_value  (rd_value),
        .rd_valid  (rd_valid),
        .fault_req (fault_req),
        .irq       (irq)
    );

    csr_result u_result (
        .clk             (clk),
        .reset_n         (reset_n),
        .rd_value        (rd_value),
        .rd_valid        (rd_valid),
        .fault_req       (fault_req),
        .irq             (irq),
        .read_value      (read_value),
        .fault           (fault),
        .ext_int_pending (ext_int_pending),
        .sw_int_pending  (sw_int_pending)
    );

endmodule

// File: testbench/csr_unit_tb.sv
// csr unit testbench
`timescale 1ns/1ps

module csr_unit_tb;

    localparam int PEND_TIMEOUT = 8;
    localparam int RANDOM_OPS = 40;

    // model state plus the outputs it predicts for the next edge
    typedef struct packed {
        logic                            en;
        logic                            pen;
        logic                            mie_ext;
        logic                            mie_sw;
        logic                            mip_ext;
        logic                            mip_sw;
        logic [csr_arch_pkg::XLEN-1:0]   mepc;
        logic                            cause_irq;
        logic [csr_arch_pkg::CAUSE_W-1:0] cause_code;
        logic                            latched_en;
        logic [csr_arch_pkg::XLEN-1:0]   read_value;
        logic                            read_known;
        logic                            fault;
        logic                            ext_pend;
        logic                            sw_pend;
    } model_t;

    logic                          clk;
    logic                          reset_n;
    csr_bus_pkg::csr_req_t         req;
    logic                          ext_int;
    logic [csr_arch_pkg::XLEN-1:0] read_value;
    logic                          fault;
    logic                          ext_int_pending;
    logic                          sw_int_pending;

    model_t expected;
    model_t expected_q;
    logic   armed;
    logic   armed_q;
    int     checks;
    int     errors;

    csr_unit uut (
        .clk             (clk),
        .reset_n         (reset_n),
        .req             (req),
        .ext_int         (ext_int),
        .read_value      (read_value),
        .fault           (fault),
        .ext_int_pending (ext_int_pending),
        .sw_int_pending  (sw_int_pending)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] arch_view(input model_t m, input logic [11:0] addr);
        logic [31:0] w;
        w = '0;
        case (addr)
            csr_arch_pkg::ADDR_MSTATUS: begin
                w[csr_arch_pkg::BIT_MIE] = m.en;
                w[csr_arch_pkg::BIT_MPIE] = m.pen;
            end
            csr_arch_pkg::ADDR_MIE: begin
                w[csr_arch_pkg::BIT_EXT] = m.mie_ext;
                w[csr_arch_pkg::BIT_SW] = m.mie_sw;
            end
            csr_arch_pkg::ADDR_MEPC: w = m.mepc;
            csr_arch_pkg::ADDR_MCAUSE: w = {m.cause_irq, 27'b0, m.cause_code};
            csr_arch_pkg::ADDR_MIP: begin
                w[csr_arch_pkg::BIT_EXT] = m.mip_ext;
                w[csr_arch_pkg::BIT_SW] = m.mip_sw;
            end
            default: w = '0;
        endcase
        return w;
    endfunction

    function automatic model_t predict(input model_t m, input csr_bus_pkg::csr_req_t r,
                                       input logic ext);
        model_t      n;
        logic        is_csr;
        logic        known_op;
        logic        known_addr;
        logic        invalid;
        logic        rd;
        logic        wr;
        logic [31:0] cur;
        logic [31:0] nv;
        n = m;
        is_csr = r.op == csr_arch_pkg::OP_CSRRW || r.op == csr_arch_pkg::OP_CSRRS
            || r.op == csr_arch_pkg::OP_CSRRC;
        known_op = is_csr || r.op == csr_arch_pkg::OP_EXCEPTION
            || r.op == csr_arch_pkg::OP_MRET || r.op == csr_arch_pkg::OP_NOP;
        known_addr = r.addr_exception == csr_arch_pkg::ADDR_MSTATUS
            || r.addr_exception == csr_arch_pkg::ADDR_MIE
            || r.addr_exception == csr_arch_pkg::ADDR_MEPC
            || r.addr_exception == csr_arch_pkg::ADDR_MCAUSE
            || r.addr_exception == csr_arch_pkg::ADDR_MIP;
        invalid = !known_op || (is_csr && !known_addr)
            || (is_csr && r.is_write_stage && r.addr_exception == csr_arch_pkg::ADDR_MCAUSE);
        rd = r.available && !r.is_write_stage && !invalid;
        wr = r.available && r.is_write_stage && !invalid;
        cur = arch_view(m, r.addr_exception);

        // outputs come from the state before this edge
        n.fault = r.available && invalid;
        n.ext_pend = m.mip_ext && m.mie_ext && m.en;
        n.sw_pend = m.mip_sw && m.mie_sw && m.en;

        if (rd && r.op == csr_arch_pkg::OP_EXCEPTION) begin
            n.read_value = csr_arch_pkg::IRQ_HANDLER_ADDR;
            n.latched_en = m.en;
        end else if (rd && r.op == csr_arch_pkg::OP_MRET) begin
            n.read_value = m.mepc;
            n.latched_en = m.pen;
        end else if (rd && is_csr) begin
            n.read_value = cur;
        end
        if (rd && r.op != csr_arch_pkg::OP_NOP) begin
            n.read_known = 1'b1;
        end

        if (wr && r.op == csr_arch_pkg::OP_EXCEPTION) begin
            n.cause_irq = r.addr_exception[csr_arch_pkg::CAUSE_W];
            n.cause_code = r.addr_exception[csr_arch_pkg::CAUSE_W-1:0];
            n.mepc = {r.write_value[31:2], 2'b00};
            n.pen = m.latched_en;
            n.en = 1'b0;
            if (r.addr_exception[csr_arch_pkg::CAUSE_W:0] == csr_arch_pkg::CAUSE_SW_IRQ) begin
                n.mip_sw = 1'b0;
            end
            if (r.addr_exception[csr_arch_pkg::CAUSE_W:0] == csr_arch_pkg::CAUSE_EXT_IRQ) begin
                n.mip_ext = 1'b0;
            end
        end else if (wr && r.op == csr_arch_pkg::OP_MRET) begin
            n.en = m.latched_en;
        end else if (wr && is_csr) begin
            if (r.op == csr_arch_pkg::OP_CSRRS) begin
                nv = cur | r.write_value;
            end else if (r.op == csr_arch_pkg::OP_CSRRC) begin
                nv = cur & ~r.write_value;
            end else begin
                nv = r.write_value;
            end
            case (r.addr_exception)
                csr_arch_pkg::ADDR_MSTATUS: begin
                    n.en = nv[csr_arch_pkg::BIT_MIE];
                    n.pen = nv[csr_arch_pkg::BIT_MPIE];
                end
                csr_arch_pkg::ADDR_MIE: begin
                    n.mie_ext = nv[csr_arch_pkg::BIT_EXT];
                    n.mie_sw = nv[csr_arch_pkg::BIT_SW];
                end
                csr_arch_pkg::ADDR_MEPC: n.mepc = {nv[31:2], 2'b00};
                csr_arch_pkg::ADDR_MIP: begin
                    n.mip_ext = nv[csr_arch_pkg::BIT_EXT];
                    n.mip_sw = nv[csr_arch_pkg::BIT_SW];
                end
                default: ;
            endcase
        end
        // external line is sticky
        if (ext) begin
            n.mip_ext = 1'b1;
        end
        return n;
    endfunction

    function automatic csr_bus_pkg::csr_req_t make_req(input logic avail, input logic wr_stage,
            input csr_arch_pkg::csr_op_e op, input logic [11:0] addr, input logic [31:0] wv);
        csr_bus_pkg::csr_req_t r;
        r.available = avail;
        r.is_write_stage = wr_stage;
        r.op = op;
        r.addr_exception = addr;
        r.write_value = wv;
        return r;
    endfunction

    function automatic logic [11:0] writable_addr(input int unsigned i);
        case (i)
            0: return csr_arch_pkg::ADDR_MSTATUS;
            1: return csr_arch_pkg::ADDR_MIE;
            2: return csr_arch_pkg::ADDR_MEPC;
            default: return csr_arch_pkg::ADDR_MIP;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("ERROR at %0t: %s is %h, expected %h", $time, name, got, want);
        end
    endtask

    // one cycle of stimulus with the model advanced alongside the DUT
    task automatic step(input csr_bus_pkg::csr_req_t r, input logic ext);
        @(posedge clk);
        #1;
        req = r;
        ext_int = ext;
        expected = predict(expected, r, ext);
        armed = 1'b1;
    endtask

    task automatic idle(input int n);
        repeat (n) step(make_req(1'b0, 1'b0, csr_arch_pkg::OP_NOP, 12'h0, 32'h0), 1'b0);
    endtask

    task automatic csr_op(input csr_arch_pkg::csr_op_e op, input logic [11:0] addr,
                          input logic [31:0] wv);
        step(make_req(1'b1, 1'b0, op, addr, wv), 1'b0);
        step(make_req(1'b1, 1'b1, op, addr, wv), 1'b0);
    endtask

    task automatic read_csr(input logic [11:0] addr);
        step(make_req(1'b1, 1'b0, csr_arch_pkg::OP_CSRRS, addr, 32'h0), 1'b0);
    endtask

    task automatic wait_for_pending(input logic ext_line, input string name);
        int n;
        n = 0;
        while ((ext_line ? ext_int_pending : sw_int_pending) !== 1'b1) begin
            if (n == PEND_TIMEOUT) begin
                $display("timeout: %s did not rise within %0d cycles", name, PEND_TIMEOUT);
                $display("*** FAILED ***");
                $finish;
            end
            idle(1);
            n++;
        end
    endtask

    // compare one cycle after each phase
    always @(posedge clk) begin
        expected_q <= expected;
        armed_q <= armed;
    end

    always @(negedge clk) begin
        if (armed_q) begin
            if (expected_q.read_known) begin
                check_value("read_value", read_value, expected_q.read_value);
            end
            check_value("fault", fault, expected_q.fault);
            check_value("ext_int_pending", ext_int_pending, expected_q.ext_pend);
            check_value("sw_int_pending", sw_int_pending, expected_q.sw_pend);
        end
    end

    initial begin
        csr_arch_pkg::csr_op_e op;
        logic [11:0]           addr;
        clk = 1'b0;
        reset_n = 1'b0;
        req = '0;
        ext_int = 1'b0;
        armed = 1'b0;
        armed_q = 1'b0;
        expected = '0;
        checks = 0;
        errors = 0;
        void'($urandom(32'h01be_3c24));
        repeat (10) @(posedge clk);
        #1 reset_n = 1'b1;

        // everything reads zero out of reset
        read_csr(csr_arch_pkg::ADDR_MSTATUS);
        read_csr(csr_arch_pkg::ADDR_MIE);
        read_csr(csr_arch_pkg::ADDR_MEPC);
        read_csr(csr_arch_pkg::ADDR_MCAUSE);
        read_csr(csr_arch_pkg::ADDR_MIP);

        for (int i = 0; i < RANDOM_OPS; i++) begin
            case ($urandom_range(2))
                0: op = csr_arch_pkg::OP_CSRRW;
                1: op = csr_arch_pkg::OP_CSRRS;
                default: op = csr_arch_pkg::OP_CSRRC;
            endcase
            addr = writable_addr($urandom_range(3));
            csr_op(op, addr, $urandom);
            read_csr(addr);
        end
        for (int i = 0; i < 4; i++) begin
            csr_op(csr_arch_pkg::OP_CSRRW, writable_addr(i), 32'h0);
        end

        // trap entry and return
        csr_op(csr_arch_pkg::OP_CSRRW, csr_arch_pkg::ADDR_MSTATUS, 32'h1 << csr_arch_pkg::BIT_MIE);
        csr_op(csr_arch_pkg::OP_EXCEPTION, 12'h002, 32'h0000_1237);
        read_csr(csr_arch_pkg::ADDR_MEPC);
        read_csr(csr_arch_pkg::ADDR_MCAUSE);
        read_csr(csr_arch_pkg::ADDR_MSTATUS);
        csr_op(csr_arch_pkg::OP_MRET, 12'h000, 32'h0);
        read_csr(csr_arch_pkg::ADDR_MSTATUS);

        // unused opcodes, unknown address, mcause write, nop
        step(make_req(1'b1, 1'b0, csr_arch_pkg::csr_op_e'(3'd2), 12'h300, 32'h8), 1'b0);
        idle(1);
        step(make_req(1'b1, 1'b0, csr_arch_pkg::csr_op_e'(3'd4), 12'h304, 32'h8), 1'b0);
        idle(1);
        step(make_req(1'b1, 1'b0, csr_arch_pkg::OP_CSRRW, 12'h7c0, 32'hffff_ffff), 1'b0);
        idle(1);
        step(make_req(1'b1, 1'b1, csr_arch_pkg::OP_CSRRW, csr_arch_pkg::ADDR_MCAUSE,
                      32'hffff_ffff), 1'b0);
        idle(1);
        csr_op(csr_arch_pkg::OP_NOP, 12'($urandom_range(12'hfff)), $urandom);
        idle(1);
        read_csr(csr_arch_pkg::ADDR_MCAUSE);

        // external interrupt
        csr_op(csr_arch_pkg::OP_CSRRW, csr_arch_pkg::ADDR_MIE, 32'h1 << csr_arch_pkg::BIT_EXT);
        csr_op(csr_arch_pkg::OP_CSRRW, csr_arch_pkg::ADDR_MSTATUS, 32'h1 << csr_arch_pkg::BIT_MIE);
        step(make_req(1'b0, 1'b0, csr_arch_pkg::OP_NOP, 12'h0, 32'h0), 1'b1);
        wait_for_pending(1'b1, "ext_int_pending");
        read_csr(csr_arch_pkg::ADDR_MIP);
        csr_op(csr_arch_pkg::OP_EXCEPTION, {7'b0, csr_arch_pkg::CAUSE_EXT_IRQ}, 32'h0000_0400);
        read_csr(csr_arch_pkg::ADDR_MIP);
        read_csr(csr_arch_pkg::ADDR_MCAUSE);
        csr_op(csr_arch_pkg::OP_MRET, 12'h000, 32'h0);

        // software interrupt raised through mip
        csr_op(csr_arch_pkg::OP_CSRRW, csr_arch_pkg::ADDR_MIE, 32'h1 << csr_arch_pkg::BIT_SW);
        csr_op(csr_arch_pkg::OP_CSRRS, csr_arch_pkg::ADDR_MIP, 32'h1 << csr_arch_pkg::BIT_SW);
        wait_for_pending(1'b0, "sw_int_pending");
        csr_op(csr_arch_pkg::OP_EXCEPTION, {7'b0, csr_arch_pkg::CAUSE_SW_IRQ}, 32'h0000_0800);
        read_csr(csr_arch_pkg::ADDR_MIP);
        read_csr(csr_arch_pkg::ADDR_MCAUSE);
        idle(2);
        repeat (2) @(posedge clk);
        #1;

        $display("checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule
